// ==== pit_pkg.sv ====
// Shared widths, access and mode encodings, CPU bus and counter
// configuration types for the interval timer channel
`default_nettype none

package pit_pkg;

    localparam int BYTE_W = 8;
    // Bit 16 flags a zero preset (65536 binary, 10000 BCD)
    localparam int COUNT_W = 17;
    localparam int DIGIT_W = 4;
    localparam int BCD_DIGITS = 4;
    localparam logic [DIGIT_W-1:0] BCD_NINE = 4'd9;

    // Control word bits 5:4
    typedef enum logic [1:0] {
        ACCESS_LATCH   = 2'b00,
        ACCESS_LSB     = 2'b01,
        ACCESS_MSB     = 2'b10,
        ACCESS_LSB_MSB = 2'b11
    } access_t;

    // Control word bits 3:1, only modes 0 and 2 are kept
    typedef enum logic [2:0] {
        MODE_TERMINAL = 3'd0,
        MODE_RATE     = 3'd2
    } mode_t;

    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              write_control;
        logic              write_counter;
        logic              read_counter;
    } pit_bus_t;

    typedef struct packed {
        access_t access;
        mode_t   mode;
        logic    bcd;
    } pit_config_t;

    localparam pit_config_t CONFIG_RESET = '{access: ACCESS_MSB, mode: MODE_TERMINAL, bcd: 1'b0};

endpackage

`default_nettype wire

// ==== pit_register_access.sv ====
// Control word decode, preset byte assembly, count latch and
// byte-wise read sequencing for one timer channel
`default_nettype none

module pit_register_access import pit_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  pit_bus_t             bus,
    input  logic [COUNT_W-1:0]   count,
    output pit_config_t          counter_config,
    output logic [COUNT_W-1:0]   preset,
    output logic                 config_update,
    output logic                 preset_loaded,
    output logic                 counting,
    output logic [BYTE_W-1:0]    read_data
);

    access_t              new_access;
    mode_t                new_mode;
    logic                 cmd_latch;
    logic [COUNT_W-2:0]   preset_value;
    logic                 write_lsb;
    logic                 read_lsb;
    logic                 prev_read;
    logic                 read_fall;
    logic                 latched;
    logic [COUNT_W-1:0]   latched_count;

    assign new_access = access_t'(bus.data[5:4]);
    // Mode fields 2 and 6 select the rate generator, all others mode 0
    assign new_mode = (bus.data[2:1] == 2'b10) ? MODE_RATE : MODE_TERMINAL;

    assign cmd_latch = bus.write_control && (new_access == ACCESS_LATCH);
    assign config_update = bus.write_control && (new_access != ACCESS_LATCH);
    assign preset_loaded = bus.write_counter;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counter_config <= CONFIG_RESET;
        end else if (config_update) begin
            counter_config.access <= new_access;
            counter_config.mode <= new_mode;
            counter_config.bcd <= bus.data[0];
        end
    end

    // Preset bytes, the unwritten byte is kept
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            preset_value <= '0;
        end else if (bus.write_counter) begin
            if (write_lsb) begin
                preset_value[BYTE_W-1:0] <= bus.data;
            end else begin
                preset_value[2*BYTE_W-1:BYTE_W] <= bus.data;
            end
        end
    end

    assign preset = {(preset_value == '0), preset_value};

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_lsb <= 1'b0;
        end else if (config_update) begin
            write_lsb <= (new_access != ACCESS_MSB);
        end else if (bus.write_counter && (counter_config.access == ACCESS_LSB_MSB)) begin
            write_lsb <= !write_lsb;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counting <= 1'b0;
        end else if (config_update) begin
            counting <= 1'b0;
        end else if (bus.write_counter) begin
            if (counter_config.access != ACCESS_LSB_MSB) begin
                counting <= 1'b1;
            end else if (counter_config.mode == MODE_RATE) begin
                // Once started, a new LSB does not stop the rate generator
                counting <= counting || !write_lsb;
            end else begin
                counting <= !write_lsb;
            end
        end
    end

    // Read strobe falling edge advances the read sequence
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_read <= 1'b0;
        end else begin
            prev_read <= bus.read_counter;
        end
    end

    assign read_fall = prev_read && !bus.read_counter;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_lsb <= 1'b0;
        end else if (config_update) begin
            read_lsb <= (new_access != ACCESS_MSB);
        end else if (read_fall && (counter_config.access == ACCESS_LSB_MSB)) begin
            read_lsb <= !read_lsb;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            latched <= 1'b0;
        end else if (cmd_latch) begin
            latched <= 1'b1;
        end else if (latched && read_fall) begin
            // In LSB_MSB order the freeze lasts until the MSB is read
            if ((counter_config.access != ACCESS_LSB_MSB) || !read_lsb) begin
                latched <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            latched_count <= '0;
        end else if (!latched) begin
            latched_count <= count;
        end
    end

    assign read_data = read_lsb ? latched_count[BYTE_W-1:0]
                                : latched_count[2*BYTE_W-1:BYTE_W];

endmodule

`default_nettype wire

// ==== pit_down_counter.sv ====
// Counting block with counter_clock edge detect, binary or BCD decrement,
// preset reload, gating and the mode 0 and mode 2 output waveform
`default_nettype none

module pit_down_counter import pit_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  pit_config_t          counter_config,
    input  logic [COUNT_W-1:0]   preset,
    input  logic                 config_update,
    input  logic                 preset_loaded,
    input  logic                 counting,
    input  logic                 counter_clock,
    input  logic                 counter_gate,
    output logic [COUNT_W-1:0]   count,
    output logic                 counter_out
);

    logic                 prev_clock;
    logic                 count_event;
    logic                 pending_load;
    logic [COUNT_W-1:0]   dec_count;
    logic [COUNT_W-1:0]   count_next;
    logic                 out_next;

    function automatic logic [COUNT_W-1:0] decrement(
        input logic [COUNT_W-1:0] value,
        input logic               bcd
    );
        logic [COUNT_W-1:0] result;
        logic               borrow;
        result = value;
        borrow = 1'b1;
        if (!bcd) begin
            result = value - 1'b1;
        end else begin
            // Ripple the borrow through the decimal digits
            for (int i = 0; i < BCD_DIGITS; i++) begin
                if (borrow) begin
                    if (value[DIGIT_W*i +: DIGIT_W] == '0) begin
                        result[DIGIT_W*i +: DIGIT_W] = BCD_NINE;
                    end else begin
                        result[DIGIT_W*i +: DIGIT_W] = value[DIGIT_W*i +: DIGIT_W] - 1'b1;
                        borrow = 1'b0;
                    end
                end
            end
            // 10000 drops to 9999
            if (borrow) begin
                result[COUNT_W-1] = 1'b0;
            end
        end
        return result;
    endfunction

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_clock <= 1'b0;
        end else begin
            prev_clock <= counter_clock;
        end
    end

    assign count_event = prev_clock && !counter_clock;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pending_load <= 1'b0;
        end else if (preset_loaded) begin
            pending_load <= 1'b1;
        end else if (count_event || config_update) begin
            pending_load <= 1'b0;
        end
    end

    assign dec_count = decrement(count, counter_config.bcd);

    always_comb begin
        if (pending_load || (count == '0)) begin
            count_next = preset;
        end else if (!counter_gate) begin
            count_next = count;
        end else if ((counter_config.mode == MODE_RATE) && (dec_count == '0)) begin
            count_next = preset;
        end else begin
            count_next = dec_count;
        end
    end

    always_comb begin
        if (counter_config.mode == MODE_RATE) begin
            out_next = !(counter_gate && (count_next == COUNT_W'(1)));
        end else begin
            // Terminal count output stays high until a new load
            out_next = (count_next == '0) || (counter_out && !pending_load);
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
            counter_out <= 1'b0;
        end else if (!counting) begin
            count <= '0;
            counter_out <= (counter_config.mode == MODE_RATE);
        end else if (count_event) begin
            count <= count_next;
            counter_out <= out_next;
        end else if ((counter_config.mode == MODE_RATE) && !counter_gate) begin
            counter_out <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== pit_counter.sv ====
// Timer channel top: register access block and counting block
`default_nettype none

module pit_counter import pit_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  pit_bus_t            bus,
    input  logic                counter_clock,
    input  logic                counter_gate,
    output logic [BYTE_W-1:0]   read_data,
    output logic                counter_out
);

    pit_config_t          counter_config;
    logic [COUNT_W-1:0]   preset;
    logic [COUNT_W-1:0]   count;
    logic                 config_update;
    logic                 preset_loaded;
    logic                 counting;

    pit_register_access u_register_access (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus),
        .count          (count),
        .counter_config (counter_config),
        .preset         (preset),
        .config_update  (config_update),
        .preset_loaded  (preset_loaded),
        .counting       (counting),
        .read_data      (read_data)
    );

    pit_down_counter u_down_counter (
        .clock          (clock),
        .reset          (reset),
        .counter_config (counter_config),
        .preset         (preset),
        .config_update  (config_update),
        .preset_loaded  (preset_loaded),
        .counting       (counting),
        .counter_clock  (counter_clock),
        .counter_gate   (counter_gate),
        .count          (count),
        .counter_out    (counter_out)
    );

endmodule

`default_nettype wire

// ==== pit_counter_properties.sv ====
// Bound assertions on the timer channel ports and configuration
`default_nettype none

module pit_counter_properties import pit_pkg::*; (
    input logic        clock,
    input logic        reset,
    input pit_bus_t    bus,
    input logic        counter_clock,
    input logic        counter_gate,
    input logic        counter_out,
    input pit_config_t counter_config
);

    int failures = 0;

    strobe_exclusive: assert property (@(posedge clock) disable iff (reset)
        $onehot0({bus.write_control, bus.write_counter, bus.read_counter}))
        else begin
            failures++;
            $error("More than one bus strobe is active");
        end

    out_low_after_reset: assert property (@(posedge clock) $fell(reset) |=> !counter_out)
        else begin
            failures++;
            $error("counter_out is not low after reset");
        end

    // Rate generator output is forced high while the gate is low
    rate_gate_low: assert property (@(posedge clock) disable iff (reset)
        (counter_config.mode == MODE_RATE) && !counter_gate &&
        !($past(counter_clock) && !counter_clock) |=> counter_out)
        else begin
            failures++;
            $error("counter_out is not high with gate low in mode 2");
        end

endmodule

bind pit_counter pit_counter_properties u_properties (
    .clock          (clock),
    .reset          (reset),
    .bus            (bus),
    .counter_clock  (counter_clock),
    .counter_gate   (counter_gate),
    .counter_out    (counter_out),
    .counter_config (counter_config)
);

`default_nettype wire

// ==== tb_pit_counter.sv ====
// Timer channel testbench with clock, reset, random bus traffic,
// reference model and closing report
`default_nettype none

module tb_pit_counter import pit_pkg::*; ();

    localparam int EVENT_CLOCKS = 8;
    // Counting events of the mode 0, mode 2, gate, latch and single-byte runs
    localparam int TIMEOUT_CYCLES = (108 + 152 + 24 + 12 + 21) * EVENT_CLOCKS * 2;
    localparam logic [2:0] WR_CONTROL = 3'b100;
    localparam logic [2:0] WR_COUNT = 3'b010;
    localparam logic [2:0] RD_COUNT = 3'b001;

    logic                  clock;
    logic                  reset;
    pit_bus_t              bus;
    logic                  counter_clock;
    logic                  counter_gate;
    logic [BYTE_W-1:0]     read_data;
    logic                  counter_out;
    int                    cycles = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    clock_div = 0;
    int                    value;
    logic [2*BYTE_W-1:0]   raw;
    logic                  bcd;

    // Reference model state
    access_t               m_access;
    logic                  m_rate;
    logic                  m_bcd;
    logic [2*BYTE_W-1:0]   m_preset;
    logic                  m_write_lsb;
    logic                  m_read_lsb;
    logic                  m_counting;
    logic                  m_pending;
    logic                  m_out;
    logic                  m_latched;
    logic                  m_prev_clock;
    logic                  m_prev_read;
    int                    m_count;
    int                    m_latch_val;

    pit_counter u_dut (
        .clock         (clock),
        .reset         (reset),
        .bus           (bus),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .read_data     (read_data),
        .counter_out   (counter_out)
    );

    function automatic int bcd_to_int(input logic [15:0] v);
        return v[15:12] * 1000 + v[11:8] * 100 + v[7:4] * 10 + v[3:0];
    endfunction

    function automatic logic [15:0] int_to_bcd(input int v);
        return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
    endfunction

    // Bus view of a model count where 65536 and 10000 read back as zero
    function automatic logic [15:0] count_bits(input int v);
        return m_bcd ? int_to_bcd(v % 10000) : 16'(v);
    endfunction

    function automatic int preset_value();
        if (m_preset == '0) begin
            return m_bcd ? 10000 : 65536;
        end
        return m_bcd ? bcd_to_int(m_preset) : int'(m_preset);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // One-clock strobe with a read checked while its strobe is high
    task automatic bus_cycle(input logic [2:0] strobes, input logic [BYTE_W-1:0] data);
        logic [15:0] bits;
        @(posedge clock);
        #1;
        bus = {data, strobes};
        if (strobes == RD_COUNT) begin
            @(negedge clock);
            bits = count_bits(m_latch_val);
            compare_value("read_data", m_read_lsb ? bits[7:0] : bits[15:8], read_data);
        end
        @(posedge clock);
        #1;
        bus = '0;
    endtask

    task automatic wait_events(input int n);
        repeat (n) @(negedge counter_clock);
    endtask

    initial clock = 1'b0;
    always #20 clock = !clock;

    always @(posedge clock) begin
        #1;
        clock_div = (clock_div + 1) % 4;
        if (clock_div == 0) begin
            counter_clock = !counter_clock;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    always @(posedge clock or posedge reset) begin : model
        logic count_event;
        logic read_fall;
        logic config_write;
        int   next_count;
        if (reset) begin
            m_access = ACCESS_MSB;
            m_rate = 1'b0;
            m_bcd = 1'b0;
            m_preset = '0;
            m_write_lsb = 1'b0;
            m_read_lsb = 1'b0;
            m_counting = 1'b0;
            m_pending = 1'b0;
            m_out = 1'b0;
            m_latched = 1'b0;
            m_prev_clock = 1'b0;
            m_prev_read = 1'b0;
            m_count = 0;
            m_latch_val = 0;
        end else begin
            count_event = m_prev_clock && !counter_clock;
            read_fall = m_prev_read && !bus.read_counter;
            config_write = bus.write_control && (bus.data[5:4] != 2'b00);
            if (!m_latched) begin
                m_latch_val = m_count;
            end
            if (bus.write_control && !config_write) begin
                m_latched = 1'b1;
            end else if (m_latched && read_fall &&
                         (m_access != ACCESS_LSB_MSB || !m_read_lsb)) begin
                m_latched = 1'b0;
            end
            if (!m_counting) begin
                m_count = 0;
                m_out = m_rate;
            end else if (count_event) begin
                if (m_pending || m_count == 0) begin
                    next_count = preset_value();
                end else if (!counter_gate) begin
                    next_count = m_count;
                end else begin
                    next_count = m_count - 1;
                    if (m_rate && next_count == 0) begin
                        next_count = preset_value();
                    end
                end
                if (m_rate) begin
                    m_out = !(counter_gate && next_count == 1);
                end else begin
                    m_out = (next_count == 0) || (m_out && !m_pending);
                end
                m_count = next_count;
            end else if (m_rate && !counter_gate) begin
                m_out = 1'b1;
            end
            if (bus.write_counter) begin
                m_pending = 1'b1;
            end else if (count_event || config_write) begin
                m_pending = 1'b0;
            end
            if (bus.write_counter) begin
                if (m_write_lsb) begin
                    m_preset[7:0] = bus.data;
                end else begin
                    m_preset[15:8] = bus.data;
                end
                if (m_access != ACCESS_LSB_MSB) begin
                    m_counting = 1'b1;
                end else if (m_rate) begin
                    m_counting = m_counting || !m_write_lsb;
                end else begin
                    m_counting = !m_write_lsb;
                end
                if (m_access == ACCESS_LSB_MSB) begin
                    m_write_lsb = !m_write_lsb;
                end
            end
            if (read_fall && m_access == ACCESS_LSB_MSB) begin
                m_read_lsb = !m_read_lsb;
            end
            if (config_write) begin
                m_access = access_t'(bus.data[5:4]);
                m_rate = bus.data[3:1] inside {3'd2, 3'd6};
                m_bcd = bus.data[0];
                m_counting = 1'b0;
                m_write_lsb = (bus.data[5:4] != 2'b10);
                m_read_lsb = m_write_lsb;
            end
            m_prev_clock = counter_clock;
            m_prev_read = bus.read_counter;
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            compare_value("counter_out", m_out, counter_out);
        end
    end

    initial begin
        bus = '0;
        counter_clock = 1'b0;
        counter_gate = 1'b1;
        reset = 1'b1;
        void'($urandom(32'h36c2));
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // Default MSB access on a zero count
        bus_cycle(RD_COUNT, 8'h00);

        // Mode 0 binary runs to terminal count
        repeat (3) begin
            value = $urandom_range(1, 30);
            bus_cycle(WR_CONTROL, {2'b00, ACCESS_LSB_MSB, 3'd0, 1'b0});
            bus_cycle(WR_COUNT, value[7:0]);
            bus_cycle(WR_COUNT, value[15:8]);
            while (counter_out !== 1'b1) @(posedge clock);
            wait_events(3);
        end

        // Mode 2 with binary or BCD rate
        repeat (4) begin
            bcd = 1'($urandom_range(0, 1));
            value = $urandom_range(2, 12);
            raw = bcd ? int_to_bcd(value) : 16'(value);
            bus_cycle(WR_CONTROL, {2'b00, ACCESS_LSB_MSB,
                                   $urandom_range(0, 1) ? 3'd6 : 3'd2, bcd});
            bus_cycle(WR_COUNT, raw[7:0]);
            bus_cycle(WR_COUNT, raw[15:8]);
            wait_events(3 * value + 2);
        end

        // Gate low holds the rate generator
        repeat (3) begin
            wait_events(2);
            @(posedge clock);
            #1;
            counter_gate = 1'b0;
            bus_cycle(WR_CONTROL, 8'h00);
            bus_cycle(RD_COUNT, 8'h00);
            bus_cycle(RD_COUNT, 8'h00);
            wait_events($urandom_range(1, 3));
            bus_cycle(RD_COUNT, 8'h00);
            bus_cycle(RD_COUNT, 8'h00);
            @(posedge clock);
            #1;
            counter_gate = 1'b1;
        end

        // Latched reads while mode 0 counts
        value = $urandom_range(1000, 65535);
        bus_cycle(WR_CONTROL, {2'b00, ACCESS_LSB_MSB, 3'd0, 1'b0});
        bus_cycle(WR_COUNT, value[7:0]);
        bus_cycle(WR_COUNT, value[15:8]);
        repeat (4) begin
            wait_events(1);
            bus_cycle(WR_CONTROL, 8'h00);
            wait_events(1);
            repeat (4) bus_cycle(RD_COUNT, 8'h00);
        end

        // Single-byte access starting with a zero BCD preset
        bus_cycle(WR_CONTROL, {2'b00, ACCESS_MSB, 3'd0, 1'b0});
        bus_cycle(WR_COUNT, 8'h00);
        bus_cycle(WR_CONTROL, {2'b00, ACCESS_LSB, 3'd0, 1'b1});
        bus_cycle(WR_COUNT, 8'h00);
        wait_events(3);
        bus_cycle(RD_COUNT, 8'h00);
        repeat (3) begin
            bcd = 1'($urandom_range(0, 1));
            raw = int_to_bcd($urandom_range(0, 9999));
            bus_cycle(WR_CONTROL, {2'b00, ACCESS_MSB, 3'd0, bcd});
            bus_cycle(WR_COUNT, raw[15:8]);
            wait_events(3);
            bus_cycle(RD_COUNT, 8'h00);
            bus_cycle(WR_CONTROL, {2'b00, ACCESS_LSB, 3'd0, bcd});
            bus_cycle(WR_COUNT, raw[7:0]);
            wait_events(3);
            bus_cycle(RD_COUNT, 8'h00);
        end

        repeat (4) @(posedge clock);
        $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
                 checks, errors, u_dut.u_properties.failures);
        if (errors == 0 && u_dut.u_properties.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
pit_pkg.sv
pit_register_access.sv
pit_down_counter.sv
pit_counter.sv
pit_counter_properties.sv
tb_pit_counter.sv

// ==== Bender.yml ====
package:
  name: pit_counter

sources:
  - pit_pkg.sv
  - pit_register_access.sv
  - pit_down_counter.sv
  - pit_counter.sv
  - target: simulation
    files:
      - pit_counter_properties.sv
      - tb_pit_counter.sv
